// ==== hdl/soc_params.svh ====
// Address map, boot memory size and pad timing, included by the fabric RTL and the testbench
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Boot memory, 4 KiB window
`define BOOT_BASE 32'h0201_0000
`define BOOT_ADDR_BITS 12
`define BOOT_DEPTH_WORDS 1024

// Game controller reader, one word
`define CONT_BASE 32'h0200_0200
`define CONT_ADDR_BITS 2

// System cycle counter, low and high word
`define SCLK_BASE 32'h0200_0300
`define SCLK_ADDR_BITS 3

// Pad tick every 2**9 system clocks
`define CONT_TICK_DIV_BITS 9

// Bits shifted out per pad and frame
`define CONT_BUTTONS 8

`endif

// ==== hdl/soc_pkg.sv ====
// AXI-Lite channel payloads and slave select codes, imported by every fabric module
package soc_pkg;

	typedef enum logic [1:0] {
		OKAY = 2'd0,
		SLVERR = 2'd2,
		DECERR = 2'd3
	} axil_resp_e;

	// Decoder target, SEL_NONE answers with DECERR
	typedef enum logic [1:0] {
		SEL_BOOT,
		SEL_CONT,
		SEL_SCLK,
		SEL_NONE
	} slave_sel_e;

	// AW and AR payload
	typedef struct packed {
		logic [31:0] addr;
		logic [2:0] prot;
	} axil_addr_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0] strb;
	} axil_wdata_t;

	typedef struct packed {
		logic [31:0] data;
		axil_resp_e resp;
	} axil_rdata_t;

endpackage

// ==== hdl/axil_decoder.sv ====
// Single-master AXI-Lite address decoder, instantiated by the fabric top in front of the slaves
`include "soc_params.svh"

module axil_decoder (
	input logic clk_50mhz,
	input logic resetn,
	// Master side
	input soc_pkg::axil_addr_t s_aw, s_ar,
	input soc_pkg::axil_wdata_t s_w,
	input logic s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready,
	output logic s_awready, s_wready, s_bvalid, s_arready, s_rvalid,
	output soc_pkg::axil_resp_e s_b,
	output soc_pkg::axil_rdata_t s_r,
	// Boot memory
	output soc_pkg::axil_addr_t boot_aw, boot_ar,
	output soc_pkg::axil_wdata_t boot_w,
	output logic boot_awvalid, boot_wvalid, boot_bready, boot_arvalid, boot_rready,
	input logic boot_awready, boot_wready, boot_bvalid, boot_arready, boot_rvalid,
	input soc_pkg::axil_resp_e boot_b,
	input soc_pkg::axil_rdata_t boot_r,
	// Controller reader
	output soc_pkg::axil_addr_t cont_aw, cont_ar,
	output soc_pkg::axil_wdata_t cont_w,
	output logic cont_awvalid, cont_wvalid, cont_bready, cont_arvalid, cont_rready,
	input logic cont_awready, cont_wready, cont_bvalid, cont_arready, cont_rvalid,
	input soc_pkg::axil_resp_e cont_b,
	input soc_pkg::axil_rdata_t cont_r,
	// Cycle counter
	output soc_pkg::axil_addr_t sclk_aw, sclk_ar,
	output soc_pkg::axil_wdata_t sclk_w,
	output logic sclk_awvalid, sclk_wvalid, sclk_bready, sclk_arvalid, sclk_rready,
	input logic sclk_awready, sclk_wready, sclk_bvalid, sclk_arready, sclk_rvalid,
	input soc_pkg::axil_resp_e sclk_b,
	input soc_pkg::axil_rdata_t sclk_r
);
	import soc_pkg::*;

	slave_sel_e ar_sel, aw_sel, rd_sel, wr_sel;
	logic rd_pending, rd_issue, wr_pending, wr_issue;
	logic rd_accept, wr_accept;
	logic slv_arready, slv_rvalid, slv_awready, slv_bvalid;
	axil_addr_t rd_req, wr_req;
	axil_wdata_t wr_data;
	axil_rdata_t slv_r;
	axil_resp_e slv_b;

	function automatic slave_sel_e decode(input logic [31:0] addr);
		if ((addr >> `BOOT_ADDR_BITS) == (`BOOT_BASE >> `BOOT_ADDR_BITS))
			return SEL_BOOT;
		if ((addr >> `CONT_ADDR_BITS) == (`CONT_BASE >> `CONT_ADDR_BITS))
			return SEL_CONT;
		if ((addr >> `SCLK_ADDR_BITS) == (`SCLK_BASE >> `SCLK_ADDR_BITS))
			return SEL_SCLK;
		return SEL_NONE;
	endfunction

	assign ar_sel = decode(s_ar.addr);
	assign aw_sel = decode(s_aw.addr);

	// One read and one write in flight
	assign rd_accept = s_arvalid && !rd_pending;
	assign wr_accept = s_awvalid && s_wvalid && !wr_pending;
	assign s_arready = rd_accept;
	assign s_awready = wr_accept;
	assign s_wready = wr_accept;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			rd_pending <= 1'b0;
			rd_issue <= 1'b0;
			rd_sel <= SEL_NONE;
			wr_pending <= 1'b0;
			wr_issue <= 1'b0;
			wr_sel <= SEL_NONE;
		end else begin
			if (rd_accept) begin
				rd_pending <= 1'b1;
				rd_issue <= ar_sel != SEL_NONE;
				rd_sel <= ar_sel;
			end else begin
				if (rd_issue && slv_arready)
					rd_issue <= 1'b0;
				if (s_rvalid && s_rready)
					rd_pending <= 1'b0;
			end
			if (wr_accept) begin
				wr_pending <= 1'b1;
				wr_issue <= aw_sel != SEL_NONE;
				wr_sel <= aw_sel;
			end else begin
				if (wr_issue && slv_awready)
					wr_issue <= 1'b0;
				if (s_bvalid && s_bready)
					wr_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (rd_accept)
			rd_req <= s_ar;
		if (wr_accept) begin
			wr_req <= s_aw;
			wr_data <= s_w;
		end
	end

	// Unmapped selection falls through to a zero DECERR response
	always_comb begin
		slv_arready = 1'b0;
		slv_rvalid = 1'b0;
		slv_r = '{data: '0, resp: DECERR};
		case (rd_sel)
			SEL_BOOT: begin
				slv_arready = boot_arready;
				slv_rvalid = boot_rvalid;
				slv_r = boot_r;
			end
			SEL_CONT: begin
				slv_arready = cont_arready;
				slv_rvalid = cont_rvalid;
				slv_r = cont_r;
			end
			SEL_SCLK: begin
				slv_arready = sclk_arready;
				slv_rvalid = sclk_rvalid;
				slv_r = sclk_r;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		slv_awready = 1'b0;
		slv_bvalid = 1'b0;
		slv_b = DECERR;
		case (wr_sel)
			SEL_BOOT: begin
				slv_awready = boot_awready && boot_wready;
				slv_bvalid = boot_bvalid;
				slv_b = boot_b;
			end
			SEL_CONT: begin
				slv_awready = cont_awready && cont_wready;
				slv_bvalid = cont_bvalid;
				slv_b = cont_b;
			end
			SEL_SCLK: begin
				slv_awready = sclk_awready && sclk_wready;
				slv_bvalid = sclk_bvalid;
				slv_b = sclk_b;
			end
			default: begin
			end
		endcase
	end

	assign s_rvalid = rd_pending && !rd_issue && (rd_sel == SEL_NONE || slv_rvalid);
	assign s_r = slv_r;
	assign s_bvalid = wr_pending && !wr_issue && (wr_sel == SEL_NONE || slv_bvalid);
	assign s_b = slv_b;

	assign boot_ar = rd_req;
	assign cont_ar = rd_req;
	assign sclk_ar = rd_req;
	assign boot_arvalid = rd_issue && rd_sel == SEL_BOOT;
	assign cont_arvalid = rd_issue && rd_sel == SEL_CONT;
	assign sclk_arvalid = rd_issue && rd_sel == SEL_SCLK;
	assign boot_rready = s_rready && rd_pending && rd_sel == SEL_BOOT;
	assign cont_rready = s_rready && rd_pending && rd_sel == SEL_CONT;
	assign sclk_rready = s_rready && rd_pending && rd_sel == SEL_SCLK;

	assign boot_aw = wr_req;
	assign cont_aw = wr_req;
	assign sclk_aw = wr_req;
	assign boot_w = wr_data;
	assign cont_w = wr_data;
	assign sclk_w = wr_data;
	assign boot_awvalid = wr_issue && wr_sel == SEL_BOOT;
	assign cont_awvalid = wr_issue && wr_sel == SEL_CONT;
	assign sclk_awvalid = wr_issue && wr_sel == SEL_SCLK;
	assign boot_wvalid = boot_awvalid;
	assign cont_wvalid = cont_awvalid;
	assign sclk_wvalid = sclk_awvalid;
	assign boot_bready = s_bready && wr_pending && wr_sel == SEL_BOOT;
	assign cont_bready = s_bready && wr_pending && wr_sel == SEL_CONT;
	assign sclk_bready = s_bready && wr_pending && wr_sel == SEL_SCLK;

	// Responses toward the master hold until taken
	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		s_rvalid && !s_rready |=> s_rvalid && $stable(s_r));
	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		s_bvalid && !s_bready |=> s_bvalid && $stable(s_b));
	// At most one slave busy on the read channel
	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$onehot0({boot_arvalid || boot_rvalid, cont_arvalid || cont_rvalid,
			sclk_arvalid || sclk_rvalid}));

endmodule

// ==== hdl/boot_ram.sv ====
// Boot memory slave with byte-strobe writes, placed behind the decoder's boot port
`include "soc_params.svh"

module boot_ram (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::axil_addr_t aw,
	input logic awvalid,
	output logic awready,
	input soc_pkg::axil_wdata_t w,
	input logic wvalid,
	output logic wready,
	output soc_pkg::axil_resp_e b,
	output logic bvalid,
	input logic bready,
	input soc_pkg::axil_addr_t ar,
	input logic arvalid,
	output logic arready,
	output soc_pkg::axil_rdata_t r,
	output logic rvalid,
	input logic rready
);
	import soc_pkg::*;

	localparam int IDX_BITS = $clog2(`BOOT_DEPTH_WORDS);

	logic [31:0] mem [`BOOT_DEPTH_WORDS];
	logic [31:0] rdata_q;
	logic wr_fire, rd_fire;

	// No new request while a response is held
	assign awready = awvalid && wvalid && !bvalid;
	assign wready = awready;
	assign arready = arvalid && !rvalid;
	assign wr_fire = awvalid && awready;
	assign rd_fire = arvalid && arready;

	always_ff @(posedge clk_50mhz) begin
		if (wr_fire) begin
			for (int i = 0; i < 4; i++) begin
				if (w.strb[i])
					mem[aw.addr[IDX_BITS+1:2]][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
		if (rd_fire)
			rdata_q <= mem[ar.addr[IDX_BITS+1:2]];
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	assign b = OKAY;
	assign r = '{data: rdata_q, resp: OKAY};

	// Decoder presents address and data together
	assert property (@(posedge clk_50mhz) disable iff (!resetn) wvalid |-> awvalid);

endmodule

// ==== hdl/system_counter.sv ====
// Read-only 64-bit cycle counter slave, low word at offset 0 and latched high word at offset 4
`include "soc_params.svh"

module system_counter (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::axil_addr_t aw,
	input logic awvalid,
	output logic awready,
	input soc_pkg::axil_wdata_t w,
	input logic wvalid,
	output logic wready,
	output soc_pkg::axil_resp_e b,
	output logic bvalid,
	input logic bready,
	input soc_pkg::axil_addr_t ar,
	input logic arvalid,
	output logic arready,
	output soc_pkg::axil_rdata_t r,
	output logic rvalid,
	input logic rready
);
	import soc_pkg::*;

	logic [63:0] count;
	logic [31:0] shadow_hi, rdata_q;
	logic lo_sel, rd_fire;

	assign lo_sel = ar.addr[`SCLK_ADDR_BITS-1:2] == '0;
	assign arready = arvalid && !rvalid;
	assign rd_fire = arvalid && arready;
	assign awready = awvalid && wvalid && !bvalid;
	assign wready = awready;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			count <= '0;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			count <= count + 64'd1;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (awready)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// Low read snapshots the high half so a later high read matches it
	always_ff @(posedge clk_50mhz) begin
		if (rd_fire) begin
			rdata_q <= lo_sel ? count[31:0] : shadow_hi;
			if (lo_sel)
				shadow_hi <= count[63:32];
		end
	end

	assign r = '{data: rdata_q, resp: OKAY};
	assign b = SLVERR;

endmodule

// ==== hdl/controller_reader.sv ====
// Serial game pad reader slave, polls two pads every frame and returns both button bytes
`include "soc_params.svh"

module controller_reader (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::axil_addr_t aw,
	input logic awvalid,
	output logic awready,
	input soc_pkg::axil_wdata_t w,
	input logic wvalid,
	output logic wready,
	output soc_pkg::axil_resp_e b,
	output logic bvalid,
	input logic bready,
	input soc_pkg::axil_addr_t ar,
	input logic arvalid,
	output logic arready,
	output soc_pkg::axil_rdata_t r,
	output logic rvalid,
	input logic rready,
	output logic c1clock,
	output logic c1latch,
	output logic c2clock,
	output logic c2latch,
	input logic c1data,
	input logic c2data
);
	import soc_pkg::*;

	// Latch tick, two ticks per bit, then idle
	localparam int BIT_TICKS = 2 * `CONT_BUTTONS;
	localparam int FRAME_LAST = BIT_TICKS + 3;
	localparam int STEP_BITS = $clog2(FRAME_LAST + 1);

	logic [`CONT_TICK_DIV_BITS-1:0] div_cnt;
	logic [STEP_BITS-1:0] step, step_nxt;
	logic tick, clk_rise, latch_q, pclk_q;
	logic [1:0] pad_data;
	logic [1:0][`CONT_BUTTONS-1:0] shift_q, buttons_q;
	logic [31:0] rdata_q;

	assign tick = &div_cnt;
	assign pad_data = {c2data, c1data};
	assign step_nxt = (step == STEP_BITS'(FRAME_LAST)) ? '0 : step + 1'b1;
	// Even ticks of the bit window raise the pad clock
	assign clk_rise = step_nxt != '0 && step_nxt <= STEP_BITS'(BIT_TICKS) && !step_nxt[0];

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			div_cnt <= '0;
			step <= STEP_BITS'(FRAME_LAST);
			latch_q <= 1'b0;
			pclk_q <= 1'b0;
			buttons_q <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			if (tick) begin
				step <= step_nxt;
				latch_q <= step_nxt == '0;
				pclk_q <= clk_rise;
				if (step_nxt == STEP_BITS'(BIT_TICKS + 1))
					buttons_q <= shift_q;
			end
		end
	end

	// Sample before the pad shifts, pins are active low
	always_ff @(posedge clk_50mhz) begin
		if (tick && clk_rise) begin
			for (int p = 0; p < 2; p++)
				shift_q[p] <= {~pad_data[p], shift_q[p][`CONT_BUTTONS-1:1]};
		end
	end

	assign c1latch = latch_q;
	assign c2latch = latch_q;
	assign c1clock = pclk_q;
	assign c2clock = pclk_q;

	assign arready = arvalid && !rvalid;
	assign awready = awvalid && wvalid && !bvalid;
	assign wready = awready;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (arready)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (awready)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// Pad 2 in the upper byte
	always_ff @(posedge clk_50mhz) begin
		if (arready)
			rdata_q <= 32'(buttons_q);
	end

	assign r = '{data: rdata_q, resp: OKAY};
	assign b = SLVERR;

	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		(c1latch || c2latch) |-> !(c1clock || c2clock));

endmodule

// ==== hdl/soc_fabric_top.sv ====
// Peripheral fabric top joining the decoder with boot memory, cycle counter and pad reader
module soc_fabric_top (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::axil_addr_t s_aw, s_ar,
	input soc_pkg::axil_wdata_t s_w,
	input logic s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready,
	output logic s_awready, s_wready, s_bvalid, s_arready, s_rvalid,
	output soc_pkg::axil_resp_e s_b,
	output soc_pkg::axil_rdata_t s_r,
	output logic c1clock,
	output logic c1latch,
	output logic c2clock,
	output logic c2latch,
	input logic c1data,
	input logic c2data
);
	import soc_pkg::*;

	axil_addr_t boot_aw, boot_ar, cont_aw, cont_ar, sclk_aw, sclk_ar;
	axil_wdata_t boot_w, cont_w, sclk_w;
	axil_resp_e boot_b, cont_b, sclk_b;
	axil_rdata_t boot_r, cont_r, sclk_r;
	logic boot_awvalid, boot_awready, boot_wvalid, boot_wready, boot_bvalid, boot_bready;
	logic boot_arvalid, boot_arready, boot_rvalid, boot_rready;
	logic cont_awvalid, cont_awready, cont_wvalid, cont_wready, cont_bvalid, cont_bready;
	logic cont_arvalid, cont_arready, cont_rvalid, cont_rready;
	logic sclk_awvalid, sclk_awready, sclk_wvalid, sclk_wready, sclk_bvalid, sclk_bready;
	logic sclk_arvalid, sclk_arready, sclk_rvalid, sclk_rready;

	// Names match the decoder ports one to one
	axil_decoder u_decoder (.*);

	boot_ram u_boot (
		.clk_50mhz, .resetn,
		.aw(boot_aw), .awvalid(boot_awvalid), .awready(boot_awready),
		.w(boot_w), .wvalid(boot_wvalid), .wready(boot_wready),
		.b(boot_b), .bvalid(boot_bvalid), .bready(boot_bready),
		.ar(boot_ar), .arvalid(boot_arvalid), .arready(boot_arready),
		.r(boot_r), .rvalid(boot_rvalid), .rready(boot_rready)
	);

	system_counter u_sclk (
		.clk_50mhz, .resetn,
		.aw(sclk_aw), .awvalid(sclk_awvalid), .awready(sclk_awready),
		.w(sclk_w), .wvalid(sclk_wvalid), .wready(sclk_wready),
		.b(sclk_b), .bvalid(sclk_bvalid), .bready(sclk_bready),
		.ar(sclk_ar), .arvalid(sclk_arvalid), .arready(sclk_arready),
		.r(sclk_r), .rvalid(sclk_rvalid), .rready(sclk_rready)
	);

	controller_reader u_cont (
		.clk_50mhz, .resetn,
		.aw(cont_aw), .awvalid(cont_awvalid), .awready(cont_awready),
		.w(cont_w), .wvalid(cont_wvalid), .wready(cont_wready),
		.b(cont_b), .bvalid(cont_bvalid), .bready(cont_bready),
		.ar(cont_ar), .arvalid(cont_arvalid), .arready(cont_arready),
		.r(cont_r), .rvalid(cont_rvalid), .rready(cont_rready),
		.c1clock, .c1latch, .c2clock, .c2latch,
		.c1data, .c2data
	);

endmodule

// ==== test/pad_model.sv ====
// Behavioral serial game pad for the testbench, loads its buttons on latch and shifts them out
`include "soc_params.svh"

module pad_model (
	input logic clock,
	input logic latch,
	input logic [`CONT_BUTTONS-1:0] buttons,
	output logic data
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [`CONT_BUTTONS-1:0] shift_reg;

	initial begin
		shift_reg = '0;
	end

	// Load on latch, next button on each rising pad clock
	always @(posedge latch or posedge clock) begin
		if (latch)
			shift_reg <= buttons;
		else
			shift_reg <= shift_reg >> 1;
	end

	// Pin is active low, bit 0 goes out first
	assign data = ~shift_reg[0];

endmodule

// ==== test/tb_soc_fabric.sv ====
// Testbench for the peripheral fabric, runs a table of bus transfers and checks every response
`include "soc_params.svh"

module tb_soc_fabric;
	timeunit 1ns;
	timeprecision 100ps;

	import soc_pkg::*;

	// Latch tick, two ticks per bit, three idle ticks
	localparam int FRAME_CYCLES = (2 * `CONT_BUTTONS + 4) << `CONT_TICK_DIV_BITS;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_COUNT, OP_PADS} op_e;

	typedef struct {
		op_e op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0] strb;
		axil_rdata_t exp;
	} step_t;

	logic clk_50mhz, resetn;
	axil_addr_t s_aw, s_ar;
	axil_wdata_t s_w;
	logic s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready;
	logic s_awready, s_wready, s_bvalid, s_arready, s_rvalid;
	axil_resp_e s_b;
	axil_rdata_t s_r;
	logic c1clock, c1latch, c2clock, c2latch, c1data, c2data;
	logic [7:0] pad1_buttons, pad2_buttons;
	step_t steps[$];
	int limit_cycles;

	soc_fabric_top uut (.*);

	pad_model u_pad1 (.clock(c1clock), .latch(c1latch), .buttons(pad1_buttons), .data(c1data));
	pad_model u_pad2 (.clock(c2clock), .latch(c2latch), .buttons(pad2_buttons), .data(c2data));

	always #10 clk_50mhz = ~clk_50mhz;

	task automatic stop_with_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_data(input axil_rdata_t got, input axil_rdata_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: s_r got %h/%s, expected %h/%s", $time,
				got.data, got.resp.name(), exp.data, exp.resp.name());
			stop_with_failure();
		end
	endtask

	task automatic check_resp(input axil_resp_e got, input axil_resp_e exp, input string sig);
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %s, expected %s", $time, sig, got.name(), exp.name());
			stop_with_failure();
		end
	endtask

	task automatic add_step(input op_e op, input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] strb, input logic [31:0] exp_data, input axil_resp_e exp_resp);
		step_t s;
		s.op = op;
		s.addr = addr;
		s.wdata = wdata;
		s.strb = strb;
		s.exp.data = exp_data;
		s.exp.resp = exp_resp;
		steps.push_back(s);
	endtask

	task automatic build_steps();
		// Boot memory, full words then byte strobes
		add_step(OP_WRITE, `BOOT_BASE + 32'h000, 32'h1234_5678, 4'hf, 32'h0, OKAY);
		add_step(OP_WRITE, `BOOT_BASE + 32'h004, 32'hcafe_f00d, 4'hf, 32'h0, OKAY);
		add_step(OP_WRITE, `BOOT_BASE + 32'hffc, 32'ha5a5_5a5a, 4'hf, 32'h0, OKAY);
		add_step(OP_WRITE, `BOOT_BASE + 32'h008, 32'h1122_3344, 4'hf, 32'h0, OKAY);
		add_step(OP_WRITE, `BOOT_BASE + 32'h008, 32'hffee_ddcc, 4'b0101, 32'h0, OKAY);
		add_step(OP_WRITE, `BOOT_BASE + 32'h004, 32'hab00_0000, 4'b1000, 32'h0, OKAY);
		add_step(OP_READ, `BOOT_BASE + 32'h000, 32'h0, 4'h0, 32'h1234_5678, OKAY);
		add_step(OP_READ, `BOOT_BASE + 32'h004, 32'h0, 4'h0, 32'habfe_f00d, OKAY);
		add_step(OP_READ, `BOOT_BASE + 32'h008, 32'h0, 4'h0, 32'h11ee_33cc, OKAY);
		add_step(OP_READ, `BOOT_BASE + 32'hffc, 32'h0, 4'h0, 32'ha5a5_5a5a, OKAY);
		// Holes in the map
		add_step(OP_READ, 32'h0300_0000, 32'h0, 4'h0, 32'h0, DECERR);
		add_step(OP_READ, 32'h0200_0400, 32'h0, 4'h0, 32'h0, DECERR);
		add_step(OP_WRITE, 32'h0300_0000, 32'hdead_beef, 4'hf, 32'h0, DECERR);
		add_step(OP_WRITE, 32'h0200_0400, 32'hdead_beef, 4'hf, 32'h0, DECERR);
		add_step(OP_READ, `BOOT_BASE + 32'h000, 32'h0, 4'h0, 32'h1234_5678, OKAY);
		// Counter, low word twice before the latched high word
		add_step(OP_COUNT, `SCLK_BASE, 32'h0, 4'h0, 32'h0, OKAY);
		add_step(OP_COUNT, `SCLK_BASE, 32'h0, 4'h0, 32'h0, OKAY);
		add_step(OP_READ, `SCLK_BASE + 32'h4, 32'h0, 4'h0, 32'h0, OKAY);
		add_step(OP_WRITE, `SCLK_BASE, 32'h0000_0001, 4'hf, 32'h0, SLVERR);
		// Pads, data word holds pad 2 above pad 1
		add_step(OP_PADS, 32'h0, 32'h0000_3ca5, 4'h0, 32'h0, OKAY);
		add_step(OP_READ, `CONT_BASE, 32'h0, 4'h0, 32'h0000_3ca5, OKAY);
		add_step(OP_PADS, 32'h0, 32'h0000_5a81, 4'h0, 32'h0, OKAY);
		add_step(OP_READ, `CONT_BASE, 32'h0, 4'h0, 32'h0000_5a81, OKAY);
		add_step(OP_WRITE, `CONT_BASE, 32'h0000_00ff, 4'hf, 32'h0, SLVERR);
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output axil_resp_e got);
		@(negedge clk_50mhz);
		s_aw = '{addr: addr, prot: 3'b000};
		s_w = '{data: data, strb: strb};
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		do @(posedge clk_50mhz); while (!(s_awready && s_wready));
		@(negedge clk_50mhz);
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		s_bready = 1'b1;
		do @(posedge clk_50mhz); while (!s_bvalid);
		got = s_b;
		@(negedge clk_50mhz);
		s_bready = 1'b0;
	endtask

	task automatic bus_read(input logic [31:0] addr, input int stall, output axil_rdata_t got);
		@(negedge clk_50mhz);
		s_ar = '{addr: addr, prot: 3'b000};
		s_arvalid = 1'b1;
		do @(posedge clk_50mhz); while (!s_arready);
		@(negedge clk_50mhz);
		s_arvalid = 1'b0;
		do @(posedge clk_50mhz); while (!s_rvalid);
		// Response must wait out the stall
		repeat (stall) begin
			@(posedge clk_50mhz);
			if (!s_rvalid) begin
				$display("Read response at %h was withdrawn while rready was low", addr);
				stop_with_failure();
			end
		end
		@(negedge clk_50mhz);
		s_rready = 1'b1;
		@(posedge clk_50mhz);
		got = s_r;
		@(negedge clk_50mhz);
		s_rready = 1'b0;
	endtask

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_50mhz);
		$display("Timeout after %0d cycles, a bus transfer never completed", limit_cycles);
		stop_with_failure();
	end

	initial begin
		axil_rdata_t got_r;
		axil_resp_e got_b;
		logic [31:0] last_count;
		int stall;
		int budget;
		clk_50mhz = 1'b0;
		resetn = 1'b0;
		s_aw = '0;
		s_ar = '0;
		s_w = '0;
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		pad1_buttons = 8'h00;
		pad2_buttons = 8'h00;
		last_count = 32'h0;
		void'($urandom(32'hb2cb));
		build_steps();
		budget = 3 * FRAME_CYCLES;
		foreach (steps[i])
			budget += (steps[i].op == OP_PADS) ? 2 * FRAME_CYCLES : 200;
		limit_cycles = budget;
		repeat (2) @(posedge clk_50mhz);
		@(negedge clk_50mhz);
		resetn = 1'b1;
		foreach (steps[i]) begin
			stall = int'($urandom_range(3, 0));
			case (steps[i].op)
				OP_WRITE: begin
					bus_write(steps[i].addr, steps[i].wdata, steps[i].strb, got_b);
					check_resp(got_b, steps[i].exp.resp, "s_b");
				end
				OP_READ: begin
					bus_read(steps[i].addr, stall, got_r);
					check_data(got_r, steps[i].exp);
				end
				OP_COUNT: begin
					bus_read(steps[i].addr, stall, got_r);
					check_resp(got_r.resp, steps[i].exp.resp, "s_r.resp");
					if (got_r.data <= last_count) begin
						$display("FAILED at %0t: s_r.data got %h, expected above %h", $time,
							got_r.data, last_count);
						stop_with_failure();
					end
					last_count = got_r.data;
				end
				OP_PADS: begin
					@(negedge clk_50mhz);
					pad1_buttons = steps[i].wdata[7:0];
					pad2_buttons = steps[i].wdata[15:8];
					repeat (2 * FRAME_CYCLES) @(posedge clk_50mhz);
				end
				default: begin
				end
			endcase
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/soc_pkg.sv
hdl/axil_decoder.sv
hdl/boot_ram.sv
hdl/system_counter.sv
hdl/controller_reader.sv
hdl/soc_fabric_top.sv
test/pad_model.sv
test/tb_soc_fabric.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_soc_fabric \
	-Mdir obj_dir -o tb_soc_fabric > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/tb_soc_fabric > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
